// ==== design/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // requester side widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // external bus width, two word lanes
  localparam int bus_w = 64;

  // machine timer, lower and upper word of the 64-bit counter
  localparam logic [addr_w-1:0] rtc_addr_lo = 32'ha000_0048;
  localparam logic [addr_w-1:0] rtc_addr_hi = rtc_addr_lo + 32'd4;

  // load size codes
  // same encoding as axi arsize/awsize, bytes = 1 << size
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  // axi okay response
  localparam logic [1:0] resp_okay = 2'b00;

  // master port fsm states
  localparam logic [1:0] port_idle = 2'd0;
  localparam logic [1:0] port_addr = 2'd1;
  localparam logic [1:0] port_resp = 2'd2;

  // one 64-bit data beat
  // lane index is address bit 2, lane 0 is the low word
  typedef union packed {
    logic [bus_w-1:0] dword;
    logic [1:0][data_w-1:0] lane;
  } bus_beat_t;

endpackage

`default_nettype wire

// ==== design/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       req_i,
  input  wire logic                       hi_i,
  output logic [bus_pkg::data_w-1:0]      rdata_o,
  output logic                            valid_o
);

  // free running machine time
  logic [bus_pkg::bus_w-1:0] cnt_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // read response, one cycle after the request
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_o <= 1'b0;
    end
    else
    begin
      valid_o <= req_i;
    end
  end

  // selected half, captured with the request
  always_ff @(posedge clk)
  begin
    if (req_i)
    begin
      rdata_o <= hi_i ? cnt_q[63:32] : cnt_q[31:0];
    end
  end

  // one read in flight, so requests never come back to back
  assert property (@(posedge clk) disable iff (rst) req_i |=> !req_i)
    else $error("timer request while the previous one is answered");

endmodule

`default_nettype wire

// ==== design/axi_master_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_master_port (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // request from the arbiter
  input  wire logic                        req_i,
  input  wire logic                        write_i,
  input  wire logic [bus_pkg::addr_w-1:0]  addr_i,
  input  wire logic [1:0]                  size_i,
  input  wire logic [bus_pkg::data_w-1:0]  wdata_i,
  input  wire logic [3:0]                  wstrb_i,
  output logic                             done_o,
  output logic [bus_pkg::data_w-1:0]       rdata_o,
  // axi read address and data
  output logic [bus_pkg::addr_w-1:0]       m_araddr_o,
  output logic [2:0]                       m_arsize_o,
  output logic                             m_arvalid_o,
  input  wire logic                        m_arready_i,
  input  wire logic [bus_pkg::bus_w-1:0]   m_rdata_i,
  input  wire logic [1:0]                  m_rresp_i,
  input  wire logic                        m_rvalid_i,
  output logic                             m_rready_o,
  // axi write address, data and response
  output logic [bus_pkg::addr_w-1:0]       m_awaddr_o,
  output logic [2:0]                       m_awsize_o,
  output logic                             m_awvalid_o,
  input  wire logic                        m_awready_i,
  output logic [bus_pkg::bus_w-1:0]        m_wdata_o,
  output logic [7:0]                       m_wstrb_o,
  output logic                             m_wvalid_o,
  input  wire logic                        m_wready_i,
  input  wire logic [1:0]                  m_bresp_i,
  input  wire logic                        m_bvalid_i,
  output logic                             m_bready_o
);

  logic [1:0]                  state_q;
  logic                        write_q;
  logic [bus_pkg::addr_w-1:0]  addr_q;
  logic [1:0]                  size_q;
  logic [bus_pkg::data_w-1:0]  wdata_q;
  logic [3:0]                  wstrb_q;
  bus_pkg::bus_beat_t          rbeat;
  bus_pkg::bus_beat_t          wbeat;
  logic [bus_pkg::data_w-1:0]  rlane;
  logic [bus_pkg::data_w-1:0]  rshift;
  logic [bus_pkg::data_w-1:0]  rvalue;
  logic                        aw_done;
  logic                        w_done;

  // aw and w each finish on their own ready
  assign aw_done = !m_awvalid_o || m_awready_i;
  assign w_done  = !m_wvalid_o || m_wready_i;

  // read lane pick, then shift the addressed byte down to bit 0
  assign rbeat  = m_rdata_i;
  assign rlane  = rbeat.lane[addr_q[2]];
  assign rshift = rlane >> {addr_q[1:0], 3'b000};

  // zero extend to the load size
  always_comb
  begin
    case (size_q)
      bus_pkg::size_byte: rvalue = {24'b0, rshift[7:0]};
      bus_pkg::size_half: rvalue = {16'b0, rshift[15:0]};
      default:            rvalue = rshift;
    endcase
  end

  // store word sits in both lanes, the strobe picks the real one
  assign wbeat.lane[0] = wdata_q;
  assign wbeat.lane[1] = wdata_q;
  assign m_wdata_o     = wbeat.dword;
  assign m_wstrb_o     = addr_q[2] ? {wstrb_q, 4'b0} : {4'b0, wstrb_q};

  assign m_araddr_o = addr_q;
  assign m_awaddr_o = addr_q;
  assign m_arsize_o = {1'b0, size_q};
  assign m_awsize_o = {1'b0, size_q};
  assign m_rready_o = 1'b1;
  assign m_bready_o = 1'b1;

  // handshake fsm
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= bus_pkg::port_idle;
      m_arvalid_o <= 1'b0;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
      done_o      <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state_q)
        bus_pkg::port_idle:
        begin
          if (req_i)
          begin
            m_arvalid_o <= !write_i;
            m_awvalid_o <= write_i;
            m_wvalid_o  <= write_i;
            state_q     <= bus_pkg::port_addr;
          end
        end
        bus_pkg::port_addr:
        begin
          if (write_q)
          begin
            if (m_awready_i)
            begin
              m_awvalid_o <= 1'b0;
            end
            if (m_wready_i)
            begin
              m_wvalid_o <= 1'b0;
            end
            if (aw_done && w_done)
            begin
              state_q <= bus_pkg::port_resp;
            end
          end
          else if (m_arready_i)
          begin
            m_arvalid_o <= 1'b0;
            state_q     <= bus_pkg::port_resp;
          end
        end
        default:
        begin
          // r beat for loads, b for stores
          if ((write_q && m_bvalid_i) || (!write_q && m_rvalid_i))
          begin
            done_o  <= 1'b1;
            state_q <= bus_pkg::port_idle;
          end
        end
      endcase
    end
  end

  // request fields, taken only while idle
  always_ff @(posedge clk)
  begin
    if (req_i && state_q == bus_pkg::port_idle)
    begin
      write_q <= write_i;
      addr_q  <= addr_i;
      size_q  <= size_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (state_q == bus_pkg::port_resp && !write_q && m_rvalid_i)
    begin
      rdata_o <= rvalue;
    end
  end

  // slave must never flag an error
  assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rresp_i == bus_pkg::resp_okay)
    else $error("read response not okay");

  assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_bresp_i == bus_pkg::resp_okay)
    else $error("write response not okay");

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // fetch
  input  wire logic                        ifu_arvalid_i,
  input  wire logic [bus_pkg::addr_w-1:0]  ifu_araddr_i,
  output logic                             ifu_rvalid_o,
  output logic [bus_pkg::data_w-1:0]       ifu_rdata_o,
  // load
  input  wire logic                        lsu_arvalid_i,
  input  wire logic [bus_pkg::addr_w-1:0]  lsu_araddr_i,
  input  wire logic [1:0]                  lsu_rsize_i,
  output logic                             lsu_rvalid_o,
  output logic [bus_pkg::data_w-1:0]       lsu_rdata_o,
  // store
  input  wire logic                        lsu_awvalid_i,
  input  wire logic [bus_pkg::addr_w-1:0]  lsu_awaddr_i,
  input  wire logic [bus_pkg::data_w-1:0]  lsu_wdata_i,
  input  wire logic [3:0]                  lsu_wstrb_i,
  output logic                             lsu_wready_o,
  // master port
  output logic                             mp_req_o,
  output logic                             mp_write_o,
  output logic [bus_pkg::addr_w-1:0]       mp_addr_o,
  output logic [1:0]                       mp_size_o,
  output logic [bus_pkg::data_w-1:0]       mp_wdata_o,
  output logic [3:0]                       mp_wstrb_o,
  input  wire logic                        mp_done_i,
  input  wire logic [bus_pkg::data_w-1:0]  mp_rdata_i,
  // timer
  output logic                             tm_req_o,
  output logic                             tm_hi_o,
  input  wire logic                        tm_valid_i,
  input  wire logic [bus_pkg::data_w-1:0]  tm_rdata_i
);

  // one-hot grant, bit 2 store, bit 1 load, bit 0 fetch
  logic [2:0]                  grant_q;
  logic                        busy_q;
  logic [2:0]                  pick;
  logic                        is_timer;
  logic                        resp_any;
  logic                        done_any;
  logic                        start;
  logic [bus_pkg::data_w-1:0]  resp_data;

  // fixed priority, store first
  always_comb
  begin
    if (lsu_awvalid_i)
    begin
      pick = 3'b100;
    end
    else if (lsu_arvalid_i)
    begin
      pick = 3'b010;
    end
    else if (ifu_arvalid_i)
    begin
      pick = 3'b001;
    end
    else
    begin
      pick = 3'b000;
    end
  end

  // only loads can hit the timer
  assign is_timer  = (lsu_araddr_i == bus_pkg::rtc_addr_lo) ||
                     (lsu_araddr_i == bus_pkg::rtc_addr_hi);
  assign resp_any  = ifu_rvalid_o | lsu_rvalid_o | lsu_wready_o;
  assign done_any  = tm_valid_i | mp_done_i;
  assign start     = !busy_q && !resp_any && (|pick);
  assign resp_data = tm_valid_i ? tm_rdata_i : mp_rdata_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant_q      <= 3'b000;
      busy_q       <= 1'b0;
      tm_req_o     <= 1'b0;
      mp_req_o     <= 1'b0;
      ifu_rvalid_o <= 1'b0;
      lsu_rvalid_o <= 1'b0;
      lsu_wready_o <= 1'b0;
    end
    else
    begin
      tm_req_o     <= 1'b0;
      mp_req_o     <= 1'b0;
      ifu_rvalid_o <= 1'b0;
      lsu_rvalid_o <= 1'b0;
      lsu_wready_o <= 1'b0;
      if (resp_any)
      begin
        // requester drops or renews valid now, so skip this cycle
        busy_q  <= 1'b0;
        grant_q <= 3'b000;
      end
      else if (start)
      begin
        busy_q   <= 1'b1;
        grant_q  <= pick;
        tm_req_o <= pick[1] && is_timer;
        mp_req_o <= !(pick[1] && is_timer);
      end
      else if (busy_q && done_any)
      begin
        ifu_rvalid_o <= grant_q[0];
        lsu_rvalid_o <= grant_q[1];
        lsu_wready_o <= grant_q[2];
      end
    end
  end

  // request fields and returned data
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      tm_hi_o    <= lsu_araddr_i == bus_pkg::rtc_addr_hi;
      mp_write_o <= pick[2];
      mp_addr_o  <= pick[2] ? lsu_awaddr_i : (pick[1] ? lsu_araddr_i : ifu_araddr_i);
      mp_size_o  <= pick[1] ? lsu_rsize_i : bus_pkg::size_word;
      mp_wdata_o <= lsu_wdata_i;
      mp_wstrb_o <= lsu_wstrb_i;
    end
    // data only to the granted reader
    if (busy_q && done_any && grant_q[0])
    begin
      ifu_rdata_o <= resp_data;
    end
    if (busy_q && done_any && grant_q[1])
    begin
      lsu_rdata_o <= resp_data;
    end
  end

  // answers only arrive for an access in flight
  assert property (@(posedge clk) disable iff (rst) done_any |-> busy_q)
    else $error("timer or port answered while idle");

  // timer answers loads only, never together with the port
  assert property (@(posedge clk) disable iff (rst)
    tm_valid_i |-> grant_q[1] && !mp_done_i)
    else $error("timer answer outside a granted load");

endmodule

`default_nettype wire

// ==== design/bus_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_subsys_top (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // fetch
  input  wire logic                        ifu_arvalid_i,
  input  wire logic [bus_pkg::addr_w-1:0]  ifu_araddr_i,
  output logic                             ifu_rvalid_o,
  output logic [bus_pkg::data_w-1:0]       ifu_rdata_o,
  // load
  input  wire logic                        lsu_arvalid_i,
  input  wire logic [bus_pkg::addr_w-1:0]  lsu_araddr_i,
  input  wire logic [1:0]                  lsu_rsize_i,
  output logic                             lsu_rvalid_o,
  output logic [bus_pkg::data_w-1:0]       lsu_rdata_o,
  // store
  input  wire logic                        lsu_awvalid_i,
  input  wire logic [bus_pkg::addr_w-1:0]  lsu_awaddr_i,
  input  wire logic [bus_pkg::data_w-1:0]  lsu_wdata_i,
  input  wire logic [3:0]                  lsu_wstrb_i,
  output logic                             lsu_wready_o,
  // axi master
  output logic [bus_pkg::addr_w-1:0]       m_araddr_o,
  output logic [2:0]                       m_arsize_o,
  output logic                             m_arvalid_o,
  input  wire logic                        m_arready_i,
  input  wire logic [bus_pkg::bus_w-1:0]   m_rdata_i,
  input  wire logic [1:0]                  m_rresp_i,
  input  wire logic                        m_rvalid_i,
  output logic                             m_rready_o,
  output logic [bus_pkg::addr_w-1:0]       m_awaddr_o,
  output logic [2:0]                       m_awsize_o,
  output logic                             m_awvalid_o,
  input  wire logic                        m_awready_i,
  output logic [bus_pkg::bus_w-1:0]        m_wdata_o,
  output logic [7:0]                       m_wstrb_o,
  output logic                             m_wvalid_o,
  input  wire logic                        m_wready_i,
  input  wire logic [1:0]                  m_bresp_i,
  input  wire logic                        m_bvalid_i,
  output logic                             m_bready_o
);

  // arbiter to master port
  logic                        mp_req;
  logic                        mp_write;
  logic [bus_pkg::addr_w-1:0]  mp_addr;
  logic [1:0]                  mp_size;
  logic [bus_pkg::data_w-1:0]  mp_wdata;
  logic [3:0]                  mp_wstrb;
  logic                        mp_done;
  logic [bus_pkg::data_w-1:0]  mp_rdata;

  // arbiter to timer
  logic                        tm_req;
  logic                        tm_hi;
  logic                        tm_valid;
  logic [bus_pkg::data_w-1:0]  tm_rdata;

  bus_arbiter u_arb (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rsize_i   (lsu_rsize_i),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wready_o  (lsu_wready_o),
    .mp_req_o      (mp_req),
    .mp_write_o    (mp_write),
    .mp_addr_o     (mp_addr),
    .mp_size_o     (mp_size),
    .mp_wdata_o    (mp_wdata),
    .mp_wstrb_o    (mp_wstrb),
    .mp_done_i     (mp_done),
    .mp_rdata_i    (mp_rdata),
    .tm_req_o      (tm_req),
    .tm_hi_o       (tm_hi),
    .tm_valid_i    (tm_valid),
    .tm_rdata_i    (tm_rdata)
  );

  clint_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .req_i   (tm_req),
    .hi_i    (tm_hi),
    .rdata_o (tm_rdata),
    .valid_o (tm_valid)
  );

  axi_master_port u_port (
    .clk         (clk),
    .rst         (rst),
    .req_i       (mp_req),
    .write_i     (mp_write),
    .addr_i      (mp_addr),
    .size_i      (mp_size),
    .wdata_i     (mp_wdata),
    .wstrb_i     (mp_wstrb),
    .done_o      (mp_done),
    .rdata_o     (mp_rdata),
    .m_araddr_o  (m_araddr_o),
    .m_arsize_o  (m_arsize_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rdata_i   (m_rdata_i),
    .m_rresp_i   (m_rresp_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o),
    .m_awaddr_o  (m_awaddr_o),
    .m_awsize_o  (m_awsize_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bresp_i   (m_bresp_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o)
  );

endmodule

`default_nettype wire

// ==== verif/axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [31:0] araddr_i,
  input  wire logic        arvalid_i,
  output logic             arready_o,
  output logic [63:0]      rdata_o,
  output logic [1:0]       rresp_o,
  output logic             rvalid_o,
  input  wire logic        rready_i,
  input  wire logic [31:0] awaddr_i,
  input  wire logic        awvalid_i,
  output logic             awready_o,
  input  wire logic [63:0] wdata_i,
  input  wire logic [7:0]  wstrb_i,
  input  wire logic        wvalid_i,
  output logic             wready_o,
  output logic [1:0]       bresp_o,
  output logic             bvalid_o,
  input  wire logic        bready_i
);

  // written words only, the rest follows the fill pattern
  logic [31:0] mem [logic [31:0]];
  logic [31:0] lcg_q;
  logic [31:0] raddr_q;
  logic [31:0] waddr_q;
  logic [63:0] wdata_q;
  logic [7:0]  wstrb_q;
  logic [1:0]  ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
  logic        r_pend, aw_got, w_got, b_pend;

  assign rresp_o = 2'b00;
  assign bresp_o = 2'b00;

  // delay of 0 to 3 cycles
  function automatic logic [1:0] rand_delay();
    lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
    return lcg_q[17:16];
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] wa);
    if (mem.exists(wa))
    begin
      return mem[wa];
    end
    return wa ^ 32'ha5a5_0000;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      lcg_q = 32'd19168;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_pend    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
      ar_cnt    <= rand_delay();
      aw_cnt    <= rand_delay();
      w_cnt     <= rand_delay();
      r_cnt     <= 2'd0;
      b_cnt     <= 2'd0;
    end
    else
    begin
      // read address, ready after a random wait
      if (arvalid_i && arready_o)
      begin
        arready_o <= 1'b0;
        raddr_q   <= araddr_i;
        r_pend    <= 1'b1;
        r_cnt     <= rand_delay();
        ar_cnt    <= rand_delay();
      end
      else if (arvalid_i && !r_pend && !rvalid_o)
      begin
        if (ar_cnt == 2'd0)
          arready_o <= 1'b1;
        else
          ar_cnt <= ar_cnt - 1'b1;
      end
      // read data beat, both word lanes of the aligned doubleword
      if (rvalid_o && rready_i)
      begin
        rvalid_o <= 1'b0;
      end
      else if (r_pend)
      begin
        if (r_cnt == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= {word_at({raddr_q[31:3], 3'b100}), word_at({raddr_q[31:3], 3'b000})};
          r_pend   <= 1'b0;
        end
        else
          r_cnt <= r_cnt - 1'b1;
      end
      // write address
      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        aw_got    <= 1'b1;
        waddr_q   <= awaddr_i;
        aw_cnt    <= rand_delay();
      end
      else if (awvalid_i && !aw_got)
      begin
        if (aw_cnt == 2'd0)
          awready_o <= 1'b1;
        else
          aw_cnt <= aw_cnt - 1'b1;
      end
      // write data
      if (wvalid_i && wready_o)
      begin
        wready_o <= 1'b0;
        w_got    <= 1'b1;
        wdata_q  <= wdata_i;
        wstrb_q  <= wstrb_i;
        w_cnt    <= rand_delay();
      end
      else if (wvalid_i && !w_got)
      begin
        if (w_cnt == 2'd0)
          wready_o <= 1'b1;
        else
          w_cnt <= w_cnt - 1'b1;
      end
      // both halves in, apply strobes per byte
      if (aw_got && w_got && !b_pend && !bvalid_o)
      begin
        for (int lane = 0; lane < 2; lane++)
        begin
          logic [31:0] wa;
          logic [31:0] w;
          wa = {waddr_q[31:3], lane[0], 2'b00};
          w  = word_at(wa);
          for (int b = 0; b < 4; b++)
          begin
            if (wstrb_q[lane * 4 + b])
              w[b * 8 +: 8] = wdata_q[lane * 32 + b * 8 +: 8];
          end
          mem[wa] = w;
        end
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_pend <= 1'b1;
        b_cnt  <= rand_delay();
      end
      // write response
      if (bvalid_o && bready_i)
      begin
        bvalid_o <= 1'b0;
      end
      else if (b_pend)
      begin
        if (b_cnt == 2'd0)
        begin
          bvalid_o <= 1'b1;
          b_pend   <= 1'b0;
        end
        else
          b_cnt <= b_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_bus_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsys;

  logic        clk = 1'b0;
  logic        rst;
  logic        ifu_arvalid, lsu_arvalid, lsu_awvalid;
  logic [31:0] ifu_araddr, lsu_araddr, lsu_awaddr, lsu_wdata;
  logic [1:0]  lsu_rsize;
  logic [3:0]  lsu_wstrb;
  logic        ifu_rvalid, lsu_rvalid, lsu_wready;
  logic [31:0] ifu_rdata, lsu_rdata;
  logic [31:0] m_araddr, m_awaddr;
  logic [2:0]  m_arsize, m_awsize;
  logic        m_arvalid, m_arready, m_rvalid, m_rready;
  logic        m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
  logic [63:0] m_rdata, m_wdata;
  logic [7:0]  m_wstrb;
  logic [1:0]  m_rresp, m_bresp;

  // shadow of memory contents, only stored words
  logic [31:0] shadow [logic [31:0]];
  logic [31:0] exp_ifu, exp_lsu, last_lo;
  logic [2:0]  exp_arsize;
  logic        ifu_pend, lsu_pend, st_pend, tm_pend, tm_lo_pend, race_q, req_seen;
  logic [2:0]  left;
  int          errors = 0;
  int          responses = 0;

  always #20 clk = ~clk;

  bus_subsys_top u_dut (
    .clk(clk), .rst(rst),
    .ifu_arvalid_i(ifu_arvalid), .ifu_araddr_i(ifu_araddr),
    .ifu_rvalid_o(ifu_rvalid), .ifu_rdata_o(ifu_rdata),
    .lsu_arvalid_i(lsu_arvalid), .lsu_araddr_i(lsu_araddr), .lsu_rsize_i(lsu_rsize),
    .lsu_rvalid_o(lsu_rvalid), .lsu_rdata_o(lsu_rdata),
    .lsu_awvalid_i(lsu_awvalid), .lsu_awaddr_i(lsu_awaddr), .lsu_wdata_i(lsu_wdata),
    .lsu_wstrb_i(lsu_wstrb), .lsu_wready_o(lsu_wready),
    .m_araddr_o(m_araddr), .m_arsize_o(m_arsize), .m_arvalid_o(m_arvalid),
    .m_arready_i(m_arready), .m_rdata_i(m_rdata), .m_rresp_i(m_rresp),
    .m_rvalid_i(m_rvalid), .m_rready_o(m_rready),
    .m_awaddr_o(m_awaddr), .m_awsize_o(m_awsize), .m_awvalid_o(m_awvalid),
    .m_awready_i(m_awready), .m_wdata_o(m_wdata), .m_wstrb_o(m_wstrb),
    .m_wvalid_o(m_wvalid), .m_wready_i(m_wready), .m_bresp_i(m_bresp),
    .m_bvalid_i(m_bvalid), .m_bready_o(m_bready)
  );

  axi_mem_model u_mem (
    .clk(clk), .rst(rst),
    .araddr_i(m_araddr), .arvalid_i(m_arvalid), .arready_o(m_arready),
    .rdata_o(m_rdata), .rresp_o(m_rresp), .rvalid_o(m_rvalid), .rready_i(m_rready),
    .awaddr_i(m_awaddr), .awvalid_i(m_awvalid), .awready_o(m_awready),
    .wdata_i(m_wdata), .wstrb_i(m_wstrb), .wvalid_i(m_wvalid), .wready_o(m_wready),
    .bresp_o(m_bresp), .bvalid_o(m_bvalid), .bready_i(m_bready)
  );

  // load goes first when pending, fetches read a whole word
  assign exp_arsize = {1'b0, (lsu_pend ? lsu_rsize : bus_pkg::size_word)};

  // fill rule, or the last stored value
  function automatic logic [31:0] word_at(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    if (shadow.exists(wa))
      return shadow[wa];
    return wa ^ 32'ha5a5_0000;
  endfunction

  // addressed bytes moved to bit 0, zero extended
  function automatic logic [31:0] load_value(input logic [31:0] a, input logic [1:0] size);
    logic [31:0] w;
    w = word_at(a) >> {a[1:0], 3'b000};
    if (size == bus_pkg::size_byte)
      return w & 32'h0000_00ff;
    if (size == bus_pkg::size_half)
      return w & 32'h0000_ffff;
    return w;
  endfunction

  task automatic issue_fetch(input logic [31:0] a);
    ifu_arvalid <= 1'b1;
    ifu_araddr  <= a;
    exp_ifu     <= word_at(a);
    ifu_pend    <= 1'b1;
    req_seen    <= 1'b1;
    left[0] = 1'b1;
  endtask

  task automatic issue_load(input logic [31:0] a, input logic [1:0] size);
    logic timer;
    timer = (a == bus_pkg::rtc_addr_lo) || (a == bus_pkg::rtc_addr_hi);
    lsu_arvalid <= 1'b1;
    lsu_araddr  <= a;
    lsu_rsize   <= size;
    // upper timer word stays zero in a short run
    exp_lsu     <= timer ? 32'd0 : load_value(a, size);
    tm_pend     <= timer;
    tm_lo_pend  <= a == bus_pkg::rtc_addr_lo;
    lsu_pend    <= 1'b1;
    req_seen    <= 1'b1;
    left[1] = 1'b1;
  endtask

  task automatic issue_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] w;
    w = word_at(a);
    for (int b = 0; b < 4; b++)
    begin
      if (s[b])
        w[b * 8 +: 8] = d[b * 8 +: 8];
    end
    shadow[{a[31:2], 2'b00}] = w;
    lsu_awvalid <= 1'b1;
    lsu_awaddr  <= a;
    lsu_wdata   <= d;
    lsu_wstrb   <= s;
    st_pend     <= 1'b1;
    req_seen    <= 1'b1;
    left[2] = 1'b1;
  endtask

  // sample at negedge, drop valids on the next rising edge
  task automatic wait_responses();
    int   cycles;
    logic f_seen, l_seen, s_seen;
    cycles = 0;
    while (left != 3'b000 && cycles < 200)
    begin
      @(negedge clk);
      f_seen = ifu_rvalid;
      l_seen = lsu_rvalid;
      s_seen = lsu_wready;
      @(posedge clk);
      if (f_seen)
      begin
        ifu_arvalid <= 1'b0;
        ifu_pend    <= 1'b0;
        left[0] = 1'b0;
        responses++;
      end
      if (l_seen)
      begin
        lsu_arvalid <= 1'b0;
        lsu_pend    <= 1'b0;
        tm_pend     <= 1'b0;
        tm_lo_pend  <= 1'b0;
        race_q      <= 1'b0;
        left[1] = 1'b0;
        responses++;
      end
      if (s_seen)
      begin
        lsu_awvalid <= 1'b0;
        st_pend     <= 1'b0;
        left[2] = 1'b0;
        responses++;
      end
      cycles++;
    end
    if (left != 3'b000)
    begin
      errors++;
      $display("timeout, an access did not complete within 200 cycles");
      ifu_arvalid <= 1'b0;
      lsu_arvalid <= 1'b0;
      lsu_awvalid <= 1'b0;
      left = 3'b000;
    end
  endtask

  // last lower timer word seen
  always @(posedge clk)
  begin
    if (rst)
      last_lo <= 32'd0;
    else if (lsu_rvalid && tm_lo_pend)
      last_lo <= lsu_rdata;
  end

  assert property (@(posedge clk) disable iff (rst) ifu_rvalid |-> ifu_rdata == exp_ifu)
    else begin
      errors++;
      $display("Error: ifu_rdata_o = 0x%08h, expected 0x%08h", $sampled(ifu_rdata),
               $sampled(exp_ifu));
    end

  assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid && !tm_lo_pend |-> lsu_rdata == exp_lsu)
    else begin
      errors++;
      $display("Error: lsu_rdata_o = 0x%08h, expected 0x%08h", $sampled(lsu_rdata),
               $sampled(exp_lsu));
    end

  // lower timer word must keep rising
  assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid && tm_lo_pend |-> lsu_rdata > last_lo)
    else begin
      errors++;
      $display("Error: lsu_rdata_o = 0x%08h, expected above 0x%08h", $sampled(lsu_rdata),
               $sampled(last_lo));
    end

  // timer load answered exactly 3 cycles after valid rises
  assert property (@(posedge clk) disable iff (rst)
    lsu_rvalid && tm_pend |-> $past(lsu_arvalid, 3) && !$past(lsu_arvalid, 4))
    else begin
      errors++;
      $display("timer load did not complete exactly 3 cycles after its request");
    end

  // pulses only for a pending requester, once each
  assert property (@(posedge clk) disable iff (rst)
    (!ifu_rvalid || ifu_pend) && (!lsu_rvalid || lsu_pend) && (!lsu_wready || st_pend))
    else begin
      errors++;
      $display("response pulse seen without a pending request");
    end

  assert property (@(posedge clk) disable iff (rst) ifu_rvalid |-> !race_q)
    else begin
      errors++;
      $display("fetch answered before the load raised in the same cycle");
    end

  assert property (@(posedge clk) disable iff (rst) m_arvalid |-> !tm_pend)
    else begin
      errors++;
      $display("AXI read issued for a timer address");
    end

  assert property (@(posedge clk) disable iff (rst) m_arvalid |-> m_arsize == exp_arsize)
    else begin
      errors++;
      $display("Error: m_arsize_o = 0x%0h, expected 0x%0h", $sampled(m_arsize),
               $sampled(exp_arsize));
    end

  // stores are word sized, the strobe selects the bytes
  assert property (@(posedge clk) disable iff (rst)
    m_awvalid |-> m_awsize == {1'b0, bus_pkg::size_word})
    else begin
      errors++;
      $display("Error: m_awsize_o = 0x%0h, expected 0x%0h", $sampled(m_awsize),
               {1'b0, bus_pkg::size_word});
    end

  assert property (@(posedge clk) disable iff (rst)
    (m_arvalid || m_awvalid || m_wvalid) |-> req_seen)
    else begin
      errors++;
      $display("AXI valid raised before any request");
    end

  initial
  begin
    rst         <= 1'b1;
    ifu_arvalid <= 1'b0;
    ifu_araddr  <= 32'd0;
    lsu_arvalid <= 1'b0;
    lsu_araddr  <= 32'd0;
    lsu_rsize   <= 2'd0;
    lsu_awvalid <= 1'b0;
    lsu_awaddr  <= 32'd0;
    lsu_wdata   <= 32'd0;
    lsu_wstrb   <= 4'd0;
    exp_ifu     <= 32'd0;
    exp_lsu     <= 32'd0;
    ifu_pend    <= 1'b0;
    lsu_pend    <= 1'b0;
    st_pend     <= 1'b0;
    tm_pend     <= 1'b0;
    tm_lo_pend  <= 1'b0;
    race_q      <= 1'b0;
    req_seen    <= 1'b0;
    left = 3'b000;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // idle stretch, port must stay quiet
    repeat (5) @(posedge clk);

    // fetches in both lanes
    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk);
      issue_fetch(32'h0000_0100 + i * 12);
      wait_responses();
    end
    // byte and half loads at every legal offset of a doubleword
    for (int off = 0; off < 8; off++)
    begin
      @(posedge clk);
      issue_load(32'h0000_0300 + off, bus_pkg::size_byte);
      wait_responses();
      if (off % 2 == 0)
      begin
        @(posedge clk);
        issue_load(32'h0000_0300 + off, bus_pkg::size_half);
        wait_responses();
      end
    end
    // stores with assorted strobes, then read back merged word
    for (int i = 0; i < 6; i++)
    begin
      @(posedge clk);
      issue_store(32'h0000_0400 + i * 4, 32'h1234_5678 + i * 32'h0101_0101, 4'(5 * i + 1));
      wait_responses();
      @(posedge clk);
      issue_load(32'h0000_0400 + i * 4, bus_pkg::size_word);
      wait_responses();
    end
    // timer, lower word twice then upper word
    for (int i = 0; i < 2; i++)
    begin
      @(posedge clk);
      issue_load(bus_pkg::rtc_addr_lo, bus_pkg::size_word);
      wait_responses();
    end
    @(posedge clk);
    issue_load(bus_pkg::rtc_addr_hi, bus_pkg::size_word);
    wait_responses();
    // fetch and load together, load has priority
    for (int i = 0; i < 2; i++)
    begin
      @(posedge clk);
      issue_fetch(32'h0000_0500 + i * 4);
      issue_load(32'h0000_0404 + i * 4, bus_pkg::size_word);
      race_q <= 1'b1;
      wait_responses();
    end

    repeat (4) @(posedge clk);
    $display("responses %0d, errors %0d", responses, errors);
    if (errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bus_subsys_top.f ====
design/bus_pkg.sv
design/clint_timer.sv
design/axi_master_port.sv
design/bus_arbiter.sv
design/bus_subsys_top.sv
verif/axi_mem_model.sv
verif/tb_bus_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass is decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bus_subsys \
  -f bus_subsys_top.f -o sim_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || true

grep -q "^Verification passed$" sim.log && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
